/* hdl/istream_pkg.sv */
`default_nettype none

package istream_pkg;

    // ------------------------------------------------------------------------
    // buffer geometry
    // ------------------------------------------------------------------------

    localparam int CHUNKS_PER_SET  = 8;
    localparam int WINDOW_CHUNKS   = 16;
    localparam int WAYS            = 4;
    localparam int ISTREAM_SETS    = 8;
    localparam int SET_INDEX_WIDTH = 3;

    localparam logic [31:0] INIT_PC = 32'h8000_0000;

    // ------------------------------------------------------------------------
    // shared types
    // ------------------------------------------------------------------------

    // one 2-byte instruction chunk
    typedef logic [15:0] chunk_t;

    // PC bits 31 to 4, base address of a fetch set
    typedef logic [27:0] pc28_t;

    typedef logic [CHUNKS_PER_SET-1:0] set_mask_t;
    typedef logic [WINDOW_CHUNKS-1:0]  window_mask_t;
    typedef logic [WAYS-1:0]           way_mask_t;

    // wrap bit on top of the set index
    typedef logic [SET_INDEX_WIDTH:0] set_ptr_t;

endpackage

`default_nettype wire

/* hdl/lsb_pick.sv */
`timescale 1ns/100ps
`default_nettype none

// lowest set request bit wins
module lsb_pick #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0]         req,
    output logic [WIDTH-1:0]         one_hot,
    output logic [WIDTH-1:0]         cold_mask,
    output logic [$clog2(WIDTH)-1:0] index
);

    logic found;

    always_comb begin
        one_hot   = '0;
        cold_mask = '0;
        index     = '0;
        found     = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            if (found) begin
                // every bit strictly above the pick
                cold_mask[i] = 1'b1;
            end else if (req[i]) begin
                one_hot[i] = 1'b1;
                index      = i[$clog2(WIDTH)-1:0];
                found      = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/set_store.sv */
`timescale 1ns/100ps
`default_nettype none

module set_store import istream_pkg::*; (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              restart,
    input  logic [31:0]                       restart_pc,
    input  logic                              enq,
    input  chunk_t [CHUNKS_PER_SET-1:0]       chunks_in,
    input  logic [31:0]                       after_pc_in,
    input  logic                              stall_sdeq,
    input  logic                              deq0_done,
    input  logic                              deq1_done,
    output logic                              full,
    output chunk_t [WINDOW_CHUNKS-1:0]        window_chunks,
    output pc28_t                             head_base,
    output pc28_t                             head_after
);

    chunk_t [CHUNKS_PER_SET-1:0] set_chunks [ISTREAM_SETS];
    pc28_t                       set_after  [ISTREAM_SETS];

    set_ptr_t enq_ptr;
    set_ptr_t deq0_ptr;
    set_ptr_t deq1_ptr;

    logic [SET_INDEX_WIDTH-1:0] enq_idx;
    logic [SET_INDEX_WIDTH-1:0] deq0_idx;
    logic [SET_INDEX_WIDTH-1:0] deq1_idx;

    assign enq_idx  = enq_ptr[SET_INDEX_WIDTH-1:0];
    assign deq0_idx = deq0_ptr[SET_INDEX_WIDTH-1:0];
    assign deq1_idx = deq1_ptr[SET_INDEX_WIDTH-1:0];

    // same slot, opposite lap
    assign full = (enq_idx == deq0_idx) &&
                  (enq_ptr[SET_INDEX_WIDTH] != deq0_ptr[SET_INDEX_WIDTH]);

    always_ff @(posedge CLK) begin
        if (enq) begin
            set_chunks[enq_idx] <= chunks_in;
            set_after[enq_idx]  <= after_pc_in[31:4];
        end
    end

    // head set low, next set high
    always_comb begin
        for (int i = 0; i < CHUNKS_PER_SET; i++) begin
            window_chunks[i]                  = set_chunks[deq0_idx][i];
            window_chunks[i + CHUNKS_PER_SET] = set_chunks[deq1_idx][i];
        end
    end

    assign head_after = set_after[deq0_idx];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_ptr   <= set_ptr_t'(0);
            deq0_ptr  <= set_ptr_t'(0);
            deq1_ptr  <= set_ptr_t'(1);
            head_base <= INIT_PC[31:4];
        end else if (restart) begin
            enq_ptr   <= set_ptr_t'(0);
            deq0_ptr  <= set_ptr_t'(0);
            deq1_ptr  <= set_ptr_t'(1);
            head_base <= restart_pc[31:4];
        end else begin
            if (enq) begin
                enq_ptr <= enq_ptr + set_ptr_t'(1);
            end
            if (!stall_sdeq && deq0_done) begin
                if (deq1_done) begin
                    deq0_ptr  <= deq0_ptr + set_ptr_t'(2);
                    deq1_ptr  <= deq1_ptr + set_ptr_t'(2);
                    head_base <= set_after[deq1_idx];
                end else begin
                    deq0_ptr  <= deq0_ptr + set_ptr_t'(1);
                    deq1_ptr  <= deq1_ptr + set_ptr_t'(1);
                    head_base <= set_after[deq0_idx];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/valid_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module valid_queue import istream_pkg::*; (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        restart,
    input  logic                        enq,
    input  set_mask_t                   valid_mask_in,
    input  chunk_t [CHUNKS_PER_SET-1:0] chunks_in,
    input  window_mask_t                ack_vec,
    input  logic                        stall_sdeq,
    input  logic                        deq0_done,
    input  logic                        deq1_done,
    output window_mask_t                window_valid,
    output window_mask_t                window_uncompressed,
    output logic [1:0]                  head_set_valid
);

    // entry 0 is always the oldest set
    set_mask_t [ISTREAM_SETS-1:0] valid_q;
    set_mask_t [ISTREAM_SETS-1:0] next_valid;
    set_mask_t [ISTREAM_SETS-1:0] uncomp_q;
    set_mask_t [ISTREAM_SETS-1:0] next_uncomp;
    logic [ISTREAM_SETS-1:0]      occ_q;
    logic [ISTREAM_SETS-1:0]      next_occ;

    logic [ISTREAM_SETS-1:0] free_one_hot;
    set_mask_t               enq_uncomp;
    logic [1:0]              shift_sets;

    // first free entry takes the new set
    lsb_pick #(
        .WIDTH(ISTREAM_SETS)
    ) u_free_pick (
        .req       (~occ_q),
        .one_hot   (free_one_hot),
        .cold_mask (),
        .index     ()
    );

    always_comb begin
        shift_sets = 2'd0;
        if (!stall_sdeq && deq0_done) begin
            shift_sets = deq1_done ? 2'd2 : 2'd1;
        end
    end

    always_comb begin
        for (int i = 0; i < CHUNKS_PER_SET; i++) begin
            enq_uncomp[i] = (chunks_in[i][1:0] == 2'b11);
        end

        next_valid  = valid_q;
        next_uncomp = uncomp_q;
        next_occ    = occ_q;

        // drop what decode takes this cycle
        if (!stall_sdeq) begin
            next_valid[0] = valid_q[0] & ~ack_vec[CHUNKS_PER_SET-1:0];
            next_valid[1] = valid_q[1] & ~ack_vec[WINDOW_CHUNKS-1:CHUNKS_PER_SET];
        end

        for (int s = 0; s < ISTREAM_SETS; s++) begin
            if (enq && free_one_hot[s]) begin
                next_occ[s]    = 1'b1;
                next_valid[s]  = valid_mask_in;
                next_uncomp[s] = enq_uncomp;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q  <= '0;
            uncomp_q <= '0;
            occ_q    <= '0;
        end else if (restart) begin
            valid_q  <= '0;
            uncomp_q <= '0;
            occ_q    <= '0;
        end else begin
            valid_q  <= next_valid >> (shift_sets * CHUNKS_PER_SET);
            uncomp_q <= next_uncomp >> (shift_sets * CHUNKS_PER_SET);
            occ_q    <= next_occ >> shift_sets;
        end
    end

    assign window_valid        = {valid_q[1], valid_q[0]};
    assign window_uncompressed = {uncomp_q[1], uncomp_q[0]};
    assign head_set_valid      = occ_q[1:0];

endmodule

`default_nettype wire

/* hdl/way_select.sv */
`timescale 1ns/100ps
`default_nettype none

module way_select import istream_pkg::*; (
    input  window_mask_t                    window_valid,
    input  window_mask_t                    window_uncompressed,
    input  chunk_t [WINDOW_CHUNKS-1:0]      window_chunks,
    input  pc28_t                           head_base,
    input  pc28_t                           head_after,
    output window_mask_t                    marker,
    output window_mask_t                    ack_vec,
    output logic                            valid_sdeq,
    output way_mask_t                       valid_by_way_sdeq,
    output way_mask_t                       uncompressed_by_way_sdeq,
    output chunk_t [WAYS-1:0][1:0]          chunk_by_way_sdeq,
    output logic [WAYS-1:0][31:0]           pc_by_way_sdeq
);

    window_mask_t [WAYS-1:0] lower_req;
    window_mask_t [WAYS-1:0] lower_oh;
    window_mask_t [WAYS-1:0] lower_cold;
    window_mask_t [WAYS-1:0] upper_req;
    window_mask_t [WAYS-1:0] upper_oh;

    logic [WAYS-1:0][$clog2(WINDOW_CHUNKS)-1:0] lower_idx;
    logic [WAYS-1:0][$clog2(WINDOW_CHUNKS)-1:0] upper_idx;

    way_mask_t is_unc;
    logic      pending;
    logic      chain_ok;

    // ------------------------------------------------------------------------
    // instruction starts
    // ------------------------------------------------------------------------

    // pending means the next valid chunk is an upper half
    always_comb begin
        pending = 1'b0;
        for (int i = 0; i < WINDOW_CHUNKS; i++) begin
            marker[i] = window_valid[i] & ~pending;
            if (window_valid[i]) begin
                pending = ~pending & window_uncompressed[i];
            end
        end
    end

    // ------------------------------------------------------------------------
    // per-way pickers
    // ------------------------------------------------------------------------

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        if (w == 0) begin : g_first
            assign lower_req[w] = marker;
        end else begin : g_next
            assign lower_req[w] = lower_req[w-1] & ~lower_oh[w-1];
        end

        // upper half is the next valid chunk past the start
        assign upper_req[w] = window_valid & lower_cold[w];

        lsb_pick #(
            .WIDTH(WINDOW_CHUNKS)
        ) u_lower (
            .req       (lower_req[w]),
            .one_hot   (lower_oh[w]),
            .cold_mask (lower_cold[w]),
            .index     (lower_idx[w])
        );

        lsb_pick #(
            .WIDTH(WINDOW_CHUNKS)
        ) u_upper (
            .req       (upper_req[w]),
            .one_hot   (upper_oh[w]),
            .cold_mask (),
            .index     (upper_idx[w])
        );
    end

    // a failed way stops every later way
    always_comb begin
        ack_vec  = '0;
        chain_ok = 1'b1;
        for (int w = 0; w < WAYS; w++) begin
            is_unc[w] = |(window_uncompressed & lower_oh[w]);
            valid_by_way_sdeq[w] = chain_ok & (|lower_req[w]) &
                                   (~is_unc[w] | (|upper_req[w]));
            chain_ok = valid_by_way_sdeq[w];
            if (valid_by_way_sdeq[w]) begin
                ack_vec = ack_vec | lower_oh[w];
                if (is_unc[w]) begin
                    ack_vec = ack_vec | upper_oh[w];
                end
            end
        end
    end

    assign valid_sdeq               = valid_by_way_sdeq[0];
    assign uncompressed_by_way_sdeq = is_unc;

    // index bit 3 selects the next set, bits 2:0 are the chunk within it
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            chunk_by_way_sdeq[w][0] = window_chunks[lower_idx[w]];
            chunk_by_way_sdeq[w][1] = is_unc[w] ? window_chunks[upper_idx[w]] : '0;
            pc_by_way_sdeq[w] = {lower_idx[w][3] ? head_after : head_base,
                                 lower_idx[w][2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* hdl/deq_advance.sv */
`timescale 1ns/100ps
`default_nettype none

module deq_advance import istream_pkg::*; (
    input  logic         CLK,
    input  logic         nRST,
    input  logic         restart,
    input  window_mask_t marker,
    input  window_mask_t window_valid,
    input  window_mask_t window_uncompressed,
    input  logic [1:0]   head_set_valid,
    input  logic         stall_sdeq,
    output logic         deq0_done,
    output logic         deq1_done
);

    window_mask_t above;
    window_mask_t dangling;
    logic         armed;
    logic         fits0;
    logic         fits01;

    // some valid chunk sits higher in the window
    always_comb begin
        for (int i = 0; i < WINDOW_CHUNKS; i++) begin
            above[i] = |(window_valid >> (i + 1));
        end
    end

    // uncompressed start still waiting on its upper half
    assign dangling = marker & window_uncompressed & ~above;

    assign fits0  = $countones(marker[CHUNKS_PER_SET-1:0]) <= WAYS;
    assign fits01 = $countones(marker) <= WAYS;

    // no retire in the first cycle out of reset or restart
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            armed <= 1'b0;
        end else begin
            armed <= ~restart;
        end
    end

    assign deq0_done = armed & ~restart & ~stall_sdeq & head_set_valid[0] & fits0 &
                       ~(|dangling[CHUNKS_PER_SET-1:0]);

    // both sets covered by the same four ways
    assign deq1_done = deq0_done & head_set_valid[1] & fits01 & ~(|dangling);

endmodule

`default_nettype wire

/* hdl/istream.sv */
`timescale 1ns/100ps
`default_nettype none

module istream import istream_pkg::*; (
    input  logic                        CLK,
    input  logic                        nRST,

    // enqueue side
    input  logic                        valid_senq,
    input  set_mask_t                   valid_mask_senq,
    input  chunk_t [CHUNKS_PER_SET-1:0] chunks_senq,
    input  logic [31:0]                 after_pc_senq,
    output logic                        stall_senq,

    // dequeue side
    output logic                        valid_sdeq,
    output way_mask_t                   valid_by_way_sdeq,
    output way_mask_t                   uncompressed_by_way_sdeq,
    output chunk_t [WAYS-1:0][1:0]      chunk_by_way_sdeq,
    output logic [WAYS-1:0][31:0]       pc_by_way_sdeq,
    input  logic                        stall_sdeq,

    input  logic                        restart,
    input  logic [31:0]                 restart_pc
);

    logic                       enq;
    logic                       full;
    chunk_t [WINDOW_CHUNKS-1:0] window_chunks;
    pc28_t                      head_base;
    pc28_t                      head_after;
    window_mask_t               window_valid;
    window_mask_t               window_uncompressed;
    logic [1:0]                 head_set_valid;
    window_mask_t               marker;
    window_mask_t               ack_vec;
    logic                       deq0_done;
    logic                       deq1_done;

    assign enq        = valid_senq & ~full;
    assign stall_senq = full;

    set_store u_set_store (
        .CLK           (CLK),
        .nRST          (nRST),
        .restart       (restart),
        .restart_pc    (restart_pc),
        .enq           (enq),
        .chunks_in     (chunks_senq),
        .after_pc_in   (after_pc_senq),
        .stall_sdeq    (stall_sdeq),
        .deq0_done     (deq0_done),
        .deq1_done     (deq1_done),
        .full          (full),
        .window_chunks (window_chunks),
        .head_base     (head_base),
        .head_after    (head_after)
    );

    valid_queue u_valid_queue (
        .CLK                 (CLK),
        .nRST                (nRST),
        .restart             (restart),
        .enq                 (enq),
        .valid_mask_in       (valid_mask_senq),
        .chunks_in           (chunks_senq),
        .ack_vec             (ack_vec),
        .stall_sdeq          (stall_sdeq),
        .deq0_done           (deq0_done),
        .deq1_done           (deq1_done),
        .window_valid        (window_valid),
        .window_uncompressed (window_uncompressed),
        .head_set_valid      (head_set_valid)
    );

    way_select u_way_select (
        .window_valid             (window_valid),
        .window_uncompressed      (window_uncompressed),
        .window_chunks            (window_chunks),
        .head_base                (head_base),
        .head_after               (head_after),
        .marker                   (marker),
        .ack_vec                  (ack_vec),
        .valid_sdeq               (valid_sdeq),
        .valid_by_way_sdeq        (valid_by_way_sdeq),
        .uncompressed_by_way_sdeq (uncompressed_by_way_sdeq),
        .chunk_by_way_sdeq        (chunk_by_way_sdeq),
        .pc_by_way_sdeq           (pc_by_way_sdeq)
    );

    deq_advance u_deq_advance (
        .CLK                 (CLK),
        .nRST                (nRST),
        .restart             (restart),
        .marker              (marker),
        .window_valid        (window_valid),
        .window_uncompressed (window_uncompressed),
        .head_set_valid      (head_set_valid),
        .stall_sdeq          (stall_sdeq),
        .deq0_done           (deq0_done),
        .deq1_done           (deq1_done)
    );

endmodule

`default_nettype wire

/* verification/istream_props.sv */
`timescale 1ns/100ps
`default_nettype none

module istream_props import istream_pkg::*; (
    input logic                   CLK,
    input logic                   nRST,
    input logic                   stall_sdeq,
    input logic                   restart,
    input logic                   valid_sdeq,
    input way_mask_t              valid_by_way_sdeq,
    input chunk_t [WAYS-1:0][1:0] chunk_by_way_sdeq,
    input logic [WAYS-1:0][31:0]  pc_by_way_sdeq
);

    a_way0_valid: assert property (@(posedge CLK) disable iff (!nRST)
        valid_sdeq == valid_by_way_sdeq[0])
        else $error("valid_sdeq differs from way 0 valid");

    // valid ways form a run starting at way 0
    a_contiguous: assert property (@(posedge CLK) disable iff (!nRST)
        (valid_by_way_sdeq & (valid_by_way_sdeq + 4'd1)) == 4'd0)
        else $error("valid ways are not contiguous from way 0");

    for (genvar w = 0; w < WAYS; w++) begin : g_hold
        a_stable: assert property (@(posedge CLK) disable iff (!nRST)
            stall_sdeq && !restart && valid_by_way_sdeq[w] |=>
                valid_by_way_sdeq[w] && $stable(pc_by_way_sdeq[w]) &&
                $stable(chunk_by_way_sdeq[w]))
            else $error("way %0d changed while decode was stalled", w);
    end

endmodule

bind istream istream_props u_props (
    .CLK               (CLK),
    .nRST              (nRST),
    .stall_sdeq        (stall_sdeq),
    .restart           (restart),
    .valid_sdeq        (valid_sdeq),
    .valid_by_way_sdeq (valid_by_way_sdeq),
    .chunk_by_way_sdeq (chunk_by_way_sdeq),
    .pc_by_way_sdeq    (pc_by_way_sdeq)
);

`default_nettype wire

/* verification/istream_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module istream_tb import istream_pkg::*; ();

    logic                         CLK;
    logic                         nRST;
    logic                         valid_senq;
    set_mask_t                    valid_mask_senq;
    chunk_t [CHUNKS_PER_SET-1:0]  chunks_senq;
    logic [31:0]                  after_pc_senq;
    logic                         stall_senq;
    logic                         valid_sdeq;
    way_mask_t                    valid_by_way_sdeq;
    way_mask_t                    uncompressed_by_way_sdeq;
    chunk_t [WAYS-1:0][1:0]       chunk_by_way_sdeq;
    logic [WAYS-1:0][31:0]        pc_by_way_sdeq;
    logic                         stall_sdeq;
    logic                         restart;
    logic [31:0]                  restart_pc;

    // record stream, see the data file for the layout
    logic [31:0] tdata [0:1023];
    logic [31:0] lcg_state;
    logic        hold;

    // expected instructions in program order
    logic [31:0] exp_pc [$];
    logic        exp_unc [$];
    chunk_t      exp_lo [$];
    chunk_t      exp_hi [$];

    istream u_dut (
        .CLK                      (CLK),
        .nRST                     (nRST),
        .valid_senq               (valid_senq),
        .valid_mask_senq          (valid_mask_senq),
        .chunks_senq              (chunks_senq),
        .after_pc_senq            (after_pc_senq),
        .stall_senq               (stall_senq),
        .valid_sdeq               (valid_sdeq),
        .valid_by_way_sdeq        (valid_by_way_sdeq),
        .uncompressed_by_way_sdeq (uncompressed_by_way_sdeq),
        .chunk_by_way_sdeq        (chunk_by_way_sdeq),
        .pc_by_way_sdeq           (pc_by_way_sdeq),
        .stall_sdeq               (stall_sdeq),
        .restart                  (restart),
        .restart_pc               (restart_pc)
    );

    always #4 CLK = ~CLK;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    task automatic stop_with(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_chunk(input string name, input chunk_t got, input chunk_t exp);
        if (got !== exp) begin
            stop_with($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_pc(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            stop_with($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    // ways seen now are taken at the coming edge
    task automatic pop_ways();
        for (int w = 0; w < WAYS; w++) begin
            if (valid_by_way_sdeq[w]) begin
                if (exp_pc.size() == 0) begin
                    stop_with($sformatf("way %0d holds an unexpected instruction at pc %h",
                                        w, pc_by_way_sdeq[w]));
                end else begin
                    check_pc($sformatf("pc_by_way_sdeq[%0d]", w),
                             pc_by_way_sdeq[w], exp_pc.pop_front());
                    check_flag($sformatf("uncompressed_by_way_sdeq[%0d]", w),
                               uncompressed_by_way_sdeq[w], exp_unc.pop_front());
                    check_chunk($sformatf("chunk_by_way_sdeq[%0d][0]", w),
                                chunk_by_way_sdeq[w][0], exp_lo.pop_front());
                    check_chunk($sformatf("chunk_by_way_sdeq[%0d][1]", w),
                                chunk_by_way_sdeq[w][1], exp_hi.pop_front());
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic run_cycle(input logic en, input set_mask_t mask,
                             input chunk_t [CHUNKS_PER_SET-1:0] chunks,
                             input logic [31:0] after, output logic acc);
        logic [31:0] r;
        @(negedge CLK);
        r               = lcg_next();
        valid_senq      = en;
        valid_mask_senq = mask;
        chunks_senq     = chunks;
        after_pc_senq   = after;
        stall_sdeq      = hold | (r[9:8] == 2'b00);
        acc             = en & ~stall_senq;
        if (!stall_sdeq) begin
            pop_ways();
        end
        @(posedge CLK);
    endtask

    task automatic send_set(input set_mask_t mask, input chunk_t [CHUNKS_PER_SET-1:0] chunks,
                            input logic [31:0] after);
        logic        acc;
        logic [31:0] r;
        int          tries;
        acc   = 1'b0;
        tries = 0;
        while (!acc) begin
            if (tries > 200) begin
                stop_with("enqueue timed out, the buffer never took the set");
            end else begin
                r = lcg_next();
                // random gap between fetch sets
                run_cycle(r[4:3] != 2'b00, mask, chunks, after, acc);
                tries++;
            end
        end
    endtask

    task automatic drain();
        logic acc;
        int   tries;
        tries = 0;
        do begin
            if (tries > 500) begin
                stop_with("timed out waiting for the expected instructions");
            end else begin
                run_cycle(1'b0, '0, '0, '0, acc);
                tries++;
            end
        end while (exp_pc.size() != 0);
    endtask

    task automatic do_restart(input logic [31:0] pc);
        @(negedge CLK);
        check_flag("stall_senq", stall_senq, 1'b1);
        valid_senq = 1'b0;
        stall_sdeq = 1'b1;
        restart    = 1'b1;
        restart_pc = pc;
        @(negedge CLK);
        restart = 1'b0;
        check_flag("valid_sdeq", valid_sdeq, 1'b0);
        check_flag("stall_senq", stall_senq, 1'b0);
    endtask

    initial begin
        int                          rp;
        logic                        done;
        chunk_t [CHUNKS_PER_SET-1:0] set_chunks;
        logic [31:0]                 r;
        CLK             = 1'b0;
        nRST            = 1'b0;
        valid_senq      = 1'b0;
        valid_mask_senq = '0;
        chunks_senq     = '0;
        after_pc_senq   = '0;
        stall_sdeq      = 1'b0;
        restart         = 1'b0;
        restart_pc      = '0;
        hold            = 1'b0;
        lcg_state       = 32'h89d2_14fe;
        $readmemh("verification/istream_testdata.txt", tdata);

        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        check_flag("valid_sdeq", valid_sdeq, 1'b0);
        check_flag("stall_senq", stall_senq, 1'b0);

        rp   = 0;
        done = 1'b0;
        while (!done) begin
            if (rp > 1000) begin
                stop_with("record stream has no end marker");
            end else begin
                case (tdata[rp])
                    32'd1: begin
                        for (int i = 0; i < CHUNKS_PER_SET; i++) begin
                            set_chunks[i] = tdata[rp + 2 + i][15:0];
                        end
                        send_set(tdata[rp + 1][7:0], set_chunks, tdata[rp + 10]);
                        rp += 11;
                    end
                    32'd4: begin
                        exp_pc.push_back(tdata[rp + 1]);
                        exp_unc.push_back(tdata[rp + 2][0]);
                        exp_lo.push_back(tdata[rp + 3][15:0]);
                        exp_hi.push_back(tdata[rp + 4][15:0]);
                        rp += 5;
                    end
                    32'd2: begin
                        // fill the buffer with junk sets, then throw them away
                        drain();
                        hold = 1'b1;
                        for (int k = 0; k < ISTREAM_SETS; k++) begin
                            for (int i = 0; i < CHUNKS_PER_SET; i++) begin
                                r             = lcg_next();
                                set_chunks[i] = r[23:8];
                            end
                            send_set(8'hff, set_chunks, 32'h1234_5670);
                        end
                        do_restart(tdata[rp + 1]);
                        hold = 1'b0;
                        rp += 2;
                    end
                    32'd3: begin
                        drain();
                        hold = 1'b1;
                        rp += 1;
                    end
                    32'd5: begin
                        @(negedge CLK);
                        valid_senq = 1'b0;
                        check_flag("stall_senq", stall_senq, 1'b1);
                        hold = 1'b0;
                        rp += 1;
                    end
                    32'd0: begin
                        drain();
                        done = 1'b1;
                    end
                    default: begin
                        stop_with($sformatf("unknown record tag %h at word %0d",
                                            tdata[rp], rp));
                    end
                endcase
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/istream_testdata.txt */
// 1 mask c0..c7 after_pc = fetch set | 4 pc unc lo hi = expected instruction
// 2 pc = restart | 3 = hold decode stall | 5 = release stall | 0 = end
1 ff 4501 0513 0010 8082 1141 00b7 1234 0297 80000010
4 80000000 0 4501 0000  4 80000002 1 0513 0010  4 80000006 0 8082 0000
4 80000008 0 1141 0000  4 8000000a 1 00b7 1234
// last chunk of the set above needs this set for its upper half
1 ff abcd 4505 0393 5678 0001 9002 6422 0141 80000020
4 8000000e 1 0297 abcd  4 80000012 0 4505 0000  4 80000014 1 0393 5678
4 80000018 0 0001 0000  4 8000001a 0 9002 0000  4 8000001c 0 6422 0000
4 8000001e 0 0141 0000
// partial masks
1 f0 dead dead dead dead 4581 0613 0020 8522 80000030
4 80000028 0 4581 0000  4 8000002a 1 0613 0020  4 8000002e 0 8522 0000
1 0f 0705 0e13 0030 4701 dead dead dead dead 80000040
4 80000030 0 0705 0000  4 80000032 1 0e13 0030  4 80000036 0 4701 0000
// fill the buffer under a held decode stall
3
1 01 1001 0 0 0 0 0 0 0 80000050  4 80000040 0 1001 0000
1 01 1005 0 0 0 0 0 0 0 80000060  4 80000050 0 1005 0000
1 01 1009 0 0 0 0 0 0 0 80000070  4 80000060 0 1009 0000
1 01 100d 0 0 0 0 0 0 0 80000080  4 80000070 0 100d 0000
1 01 1011 0 0 0 0 0 0 0 80000090  4 80000080 0 1011 0000
1 01 1015 0 0 0 0 0 0 0 800000a0  4 80000090 0 1015 0000
1 01 1019 0 0 0 0 0 0 0 800000b0  4 800000a0 0 1019 0000
1 01 101d 0 0 0 0 0 0 0 800000c0  4 800000b0 0 101d 0000
5
2 40001000
1 ff 0513 00a0 4585 0613 00b0 8082 4501 4601 40001010
4 40001000 1 0513 00a0  4 40001004 0 4585 0000  4 40001006 1 0613 00b0
4 4000100a 0 8082 0000  4 4000100c 0 4501 0000  4 4000100e 0 4601 0000
0

/* tb.f */
hdl/istream_pkg.sv
hdl/lsb_pick.sv
hdl/set_store.sv
hdl/valid_queue.sv
hdl/way_select.sv
hdl/deq_advance.sv
hdl/istream.sv
verification/istream_props.sv
verification/istream_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the istream testbench with Verilator
set -e

verilator --binary --timing --assert -f tb.f --top-module istream_tb -o sim_istream
./obj_dir/sim_istream | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    echo "simulation ok"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
